/* common/gfx_pkg.sv */
package gfx_pkg;

    ////////////////////////////////////////////////////////////////////////////
    // Widths
    ////////////////////////////////////////////////////////////////////////////

    // Video RAM word address and word
    typedef logic [12:0] vaddr_t;
    typedef logic [15:0] vword_t;

    // Palette in bits 5:4, color index below
    typedef logic [5:0] pixel_t;

    // Line buffer index
    typedef logic [8:0] pix_idx_t;

    // Scroll offsets and video line
    typedef logic [8:0] scrx_t;
    typedef logic [7:0] scry_t;
    typedef logic [7:0] vline_t;

    // Visible pixels and tiles fetched per line
    localparam int LINE_WIDTH     = 320;
    localparam int TILES_PER_LINE = 41;

    ////////////////////////////////////////////////////////////////////////////
    // APB register map
    ////////////////////////////////////////////////////////////////////////////

    localparam logic [7:0] REG_SCRX   = 8'h00;
    localparam logic [7:0] REG_SCRY   = 8'h04;
    localparam logic [7:0] REG_VADDR  = 8'h08;
    localparam logic [7:0] REG_VDATA  = 8'h0C;
    localparam logic [7:0] REG_STATUS = 8'h10;

    // Fetch engine states
    typedef enum logic [1:0] {
        ST_MAP   = 2'd0,
        ST_PAT_L = 2'd1,
        ST_PAT_H = 2'd2,
        ST_DONE  = 2'd3
    } fetch_state_t;

endpackage

/* gfx/gfx_line_fetch.sv */
`timescale 1ns/1ps

module gfx #(
    parameter int LINE_OFFSET = 15
) (
    input  logic               clk,
    input  logic               reset,

    // Register values
    input  gfx_pkg::scrx_t     scrx,
    input  gfx_pkg::scry_t     scry,

    // Render parameters
    input  gfx_pkg::vline_t    vline,
    input  logic               line_start,

    // Video RAM read port
    output gfx_pkg::vaddr_t    vaddr,
    input  gfx_pkg::vword_t    vdata,
    output logic               busy,

    // Pixel readout
    input  gfx_pkg::pix_idx_t  rd_idx,
    output gfx_pkg::pixel_t    rd_pixel
);

    gfx_pkg::fetch_state_t state_r, state_next;
    logic                  busy_r, busy_next;
    logic                  linesel_r, linesel_next;
    logic [5:0]            col_r, col_next;
    logic [5:0]            col_cnt_r, col_cnt_next;
    gfx_pkg::vword_t       map_entry_r, map_entry_next;
    gfx_pkg::vaddr_t       vaddr_r, vaddr_next;
    gfx_pkg::pix_idx_t     render_idx_r, render_idx_next;

    logic                  render_start;
    logic                  render_busy;
    logic                  render_last_pixel;
    logic                  render_ready;

    gfx_pkg::pix_idx_t     wridx;
    gfx_pkg::pixel_t       wrdata;
    logic                  wren;

    gfx_pkg::vline_t       bmline;
    gfx_pkg::vline_t       tline;
    logic [2:0]            tile_line;
    gfx_pkg::vaddr_t       vaddr_map;
    gfx_pkg::vaddr_t       vaddr_pat_l;
    gfx_pkg::vaddr_t       vaddr_pat_h;

    ////////////////////////////////////////////////////////////////////////////
    // Line buffer and renderer
    ////////////////////////////////////////////////////////////////////////////
    line_buffer i_line_buffer (
        .clk     (clk),
        .linesel (linesel_r),
        .wr_idx  (wridx),
        .wr_data (wrdata),
        .wren    (wren),
        .rd_idx  (rd_idx),
        .rd_data (rd_pixel)
    );

    tile_renderer i_renderer (
        .clk          (clk),
        .reset        (reset),
        .render_start (render_start),
        .render_data  (vdata),
        .render_idx   (render_idx_r),
        .palette      (map_entry_r[13:12]),
        .busy         (render_busy),
        .last_pixel   (render_last_pixel),
        .wren         (wren),
        .wridx        (wridx),
        .wrdata       (wrdata)
    );

    ////////////////////////////////////////////////////////////////////////////
    // Address generation
    ////////////////////////////////////////////////////////////////////////////
    assign bmline    = vline - gfx_pkg::vline_t'(LINE_OFFSET);
    assign tline     = bmline + scry;
    // Vertical flip picks the mirrored pattern line
    assign tile_line = map_entry_next[10] ? ~tline[2:0] : tline[2:0];

    assign vaddr_map   = {2'b00, tline[7:3], col_next};
    assign vaddr_pat_l = {map_entry_next[8:0], tile_line, 1'b0};
    assign vaddr_pat_h = {map_entry_next[8:0], tile_line, 1'b1};

    assign vaddr        = vaddr_next;
    assign busy         = busy_r;
    assign render_ready = !render_busy || render_last_pixel;

    ////////////////////////////////////////////////////////////////////////////
    // Fetch state machine
    ////////////////////////////////////////////////////////////////////////////
    always_comb begin
        state_next      = state_r;
        busy_next       = busy_r;
        linesel_next    = linesel_r;
        col_next        = col_r;
        col_cnt_next    = col_cnt_r;
        map_entry_next  = map_entry_r;
        vaddr_next      = vaddr_r;
        render_idx_next = render_idx_r;
        render_start    = 1'b0;

        if (line_start) begin
            state_next      = gfx_pkg::ST_MAP;
            busy_next       = 1'b1;
            linesel_next    = !linesel_r;
            col_next        = scrx[8:3];
            col_cnt_next    = 6'd0;
            vaddr_next      = vaddr_map;
            render_idx_next = 9'd0 - {6'd0, scrx[2:0]};
        end else if (busy_r) begin
            case (state_r)
                gfx_pkg::ST_MAP: begin
                    map_entry_next = vdata;
                    vaddr_next     = vaddr_pat_l;
                    state_next     = gfx_pkg::ST_PAT_L;
                    col_next       = col_r + 6'd1;
                    col_cnt_next   = col_cnt_r + 6'd1;
                end
                gfx_pkg::ST_PAT_L: begin
                    // Held here, re-reading the same word, until the renderer frees up
                    if (render_ready) begin
                        render_start = 1'b1;
                        vaddr_next   = vaddr_pat_h;
                        state_next   = gfx_pkg::ST_PAT_H;
                    end
                end
                gfx_pkg::ST_PAT_H: begin
                    if (render_ready) begin
                        render_start = 1'b1;
                        vaddr_next   = vaddr_map;
                        if (col_cnt_r == 6'(gfx_pkg::TILES_PER_LINE)) begin
                            state_next = gfx_pkg::ST_DONE;
                            busy_next  = 1'b0;
                        end else begin
                            state_next = gfx_pkg::ST_MAP;
                        end
                    end
                end
                gfx_pkg::ST_DONE: busy_next = 1'b0;
                default: state_next = gfx_pkg::ST_MAP;
            endcase

            if (render_start) begin
                render_idx_next = render_idx_r + 9'd4;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state_r   <= gfx_pkg::ST_MAP;
            busy_r    <= 1'b0;
            linesel_r <= 1'b0;
            col_r     <= '0;
            col_cnt_r <= '0;
            vaddr_r   <= '0;
        end else begin
            state_r   <= state_next;
            busy_r    <= busy_next;
            linesel_r <= linesel_next;
            col_r     <= col_next;
            col_cnt_r <= col_cnt_next;
            vaddr_r   <= vaddr_next;
        end
    end

    // Map entry and pixel index, loaded before use
    always_ff @(posedge clk) begin
        map_entry_r  <= map_entry_next;
        render_idx_r <= render_idx_next;
    end

endmodule

/* gfx/line_buffer.sv */
`timescale 1ns/1ps

module line_buffer (
    input  logic               clk,

    // Half written this line
    input  logic               linesel,

    // Renderer side
    input  gfx_pkg::pix_idx_t  wr_idx,
    input  gfx_pkg::pixel_t    wr_data,
    input  logic               wren,

    // Video side
    input  gfx_pkg::pix_idx_t  rd_idx,
    output gfx_pkg::pixel_t    rd_data
);

    localparam int DEPTH = 2 ** $bits(gfx_pkg::pix_idx_t);

    // Two line halves
    gfx_pkg::pixel_t mem [0:1][0:DEPTH-1];

    always_ff @(posedge clk) begin
        if (wren) begin
            mem[linesel][wr_idx] <= wr_data;
        end
    end

    // Other half holds the finished line
    always_ff @(posedge clk) begin
        rd_data <= mem[!linesel][rd_idx];
    end

endmodule

/* gfx/tile_renderer.sv */
`timescale 1ns/1ps

module tile_renderer (
    input  logic               clk,
    input  logic               reset,

    // Word from the fetch engine
    input  logic               render_start,
    input  gfx_pkg::vword_t    render_data,
    input  gfx_pkg::pix_idx_t  render_idx,
    input  logic [1:0]         palette,
    output logic               busy,
    output logic               last_pixel,

    // Line buffer write port
    output logic               wren,
    output gfx_pkg::pix_idx_t  wridx,
    output gfx_pkg::pixel_t    wrdata
);

    gfx_pkg::vword_t   data_r;
    gfx_pkg::pix_idx_t idx_r;
    logic [1:0]        pal_r;
    logic [1:0]        cnt_r;
    logic              busy_r;

    ////////////////////////////////////////////////////////////////////////////
    // Control
    ////////////////////////////////////////////////////////////////////////////
    always_ff @(posedge clk) begin
        if (reset) begin
            busy_r <= 1'b0;
            cnt_r  <= '0;
        end else if (render_start) begin
            busy_r <= 1'b1;
            cnt_r  <= '0;
        end else if (busy_r) begin
            cnt_r <= cnt_r + 2'd1;
            // Fourth pixel out, nothing queued
            if (cnt_r == 2'd3) begin
                busy_r <= 1'b0;
            end
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Pixel shifter
    ////////////////////////////////////////////////////////////////////////////
    always_ff @(posedge clk) begin
        if (render_start) begin
            data_r <= render_data;
            idx_r  <= render_idx;
            pal_r  <= palette;
        end else if (busy_r) begin
            data_r <= {data_r[11:0], 4'd0};
            idx_r  <= idx_r + 9'd1;
        end
    end

    assign busy       = busy_r;
    assign last_pixel = busy_r && (cnt_r == 2'd3);

    // Pixel 0 sits in the top nibble
    assign wrdata = {pal_r, data_r[15:12]};
    assign wridx  = idx_r;

    // Wrapped indices of scrolled-off pixels also land past the visible width
    assign wren = busy_r && (idx_r < gfx_pkg::pix_idx_t'(gfx_pkg::LINE_WIDTH));

endmodule

/* hw/gfx_regs.sv */
`timescale 1ns/1ps

module gfx_regs (
    input  logic             clk,
    input  logic             reset,

    // APB slave
    input  logic             psel,
    input  logic             penable,
    input  logic             pwrite,
    input  logic [7:0]       paddr,
    input  logic [31:0]      pwdata,
    output logic [31:0]      prdata,
    output logic             pready,

    // Renderer status
    input  logic             busy,

    // Register values
    output gfx_pkg::scrx_t   scrx,
    output gfx_pkg::scry_t   scry,

    // Video RAM write port
    output logic             vram_we,
    output gfx_pkg::vaddr_t  vram_waddr,
    output gfx_pkg::vword_t  vram_wdata
);

    logic            wr_access;
    gfx_pkg::vaddr_t vptr;

    // No wait states
    assign pready    = 1'b1;
    assign wr_access = psel && penable && pwrite;

    always_ff @(posedge clk) begin
        if (reset) begin
            scrx    <= '0;
            scry    <= '0;
            vptr    <= '0;
            vram_we <= 1'b0;
        end else begin
            vram_we <= 1'b0;
            if (wr_access) begin
                case (paddr)
                    gfx_pkg::REG_SCRX:  scrx <= pwdata[8:0];
                    gfx_pkg::REG_SCRY:  scry <= pwdata[7:0];
                    gfx_pkg::REG_VADDR: vptr <= pwdata[12:0];
                    gfx_pkg::REG_VDATA: begin
                        // One write strobe, pointer moves on
                        vram_we <= 1'b1;
                        vptr    <= vptr + 13'd1;
                    end
                    default: ;
                endcase
            end
        end
    end

    // Write address and data follow the strobe
    always_ff @(posedge clk) begin
        if (wr_access && paddr == gfx_pkg::REG_VDATA) begin
            vram_waddr <= vptr;
            vram_wdata <= pwdata[15:0];
        end
    end

    always_comb begin
        case (paddr)
            gfx_pkg::REG_SCRX:   prdata = {23'd0, scrx};
            gfx_pkg::REG_SCRY:   prdata = {24'd0, scry};
            gfx_pkg::REG_VADDR:  prdata = {19'd0, vptr};
            gfx_pkg::REG_STATUS: prdata = {31'd0, busy};
            default:             prdata = 32'd0;
        endcase
    end

endmodule

/* hw/gfx_top.sv */
`timescale 1ns/1ps

module gfx_top #(
    parameter int LINE_OFFSET = 15
) (
    input  logic               clk,
    input  logic               reset,

    // APB slave
    input  logic               psel,
    input  logic               penable,
    input  logic               pwrite,
    input  logic [7:0]         paddr,
    input  logic [31:0]        pwdata,
    output logic [31:0]        prdata,
    output logic               pready,

    // Video timing
    input  gfx_pkg::vline_t    vline,
    input  logic               line_start,

    // Pixel readout
    input  gfx_pkg::pix_idx_t  rd_idx,
    output gfx_pkg::pixel_t    rd_pixel
);

    gfx_pkg::scrx_t  scrx;
    gfx_pkg::scry_t  scry;
    logic            busy;

    logic            vram_we;
    gfx_pkg::vaddr_t vram_waddr;
    gfx_pkg::vword_t vram_wdata;

    gfx_pkg::vaddr_t vaddr;
    gfx_pkg::vword_t vdata;

    gfx_regs i_regs (
        .clk        (clk),
        .reset      (reset),
        .psel       (psel),
        .penable    (penable),
        .pwrite     (pwrite),
        .paddr      (paddr),
        .pwdata     (pwdata),
        .prdata     (prdata),
        .pready     (pready),
        .busy       (busy),
        .scrx       (scrx),
        .scry       (scry),
        .vram_we    (vram_we),
        .vram_waddr (vram_waddr),
        .vram_wdata (vram_wdata)
    );

    vram i_vram (
        .clk   (clk),
        .we    (vram_we),
        .waddr (vram_waddr),
        .wdata (vram_wdata),
        .raddr (vaddr),
        .rdata (vdata)
    );

    gfx #(
        .LINE_OFFSET (LINE_OFFSET)
    ) i_gfx (
        .clk        (clk),
        .reset      (reset),
        .scrx       (scrx),
        .scry       (scry),
        .vline      (vline),
        .line_start (line_start),
        .vaddr      (vaddr),
        .vdata      (vdata),
        .busy       (busy),
        .rd_idx     (rd_idx),
        .rd_pixel   (rd_pixel)
    );

endmodule

/* hw/vram.sv */
`timescale 1ns/1ps

module vram (
    input  logic             clk,

    // Write port
    input  logic             we,
    input  gfx_pkg::vaddr_t  waddr,
    input  gfx_pkg::vword_t  wdata,

    // Read port
    input  gfx_pkg::vaddr_t  raddr,
    output gfx_pkg::vword_t  rdata
);

    localparam int DEPTH = 2 ** $bits(gfx_pkg::vaddr_t);

    gfx_pkg::vword_t mem [0:DEPTH-1];

    always_ff @(posedge clk) begin
        if (we) begin
            mem[waddr] <= wdata;
        end
    end

    // Registered read, data one cycle after the address
    always_ff @(posedge clk) begin
        rdata <= mem[raddr];
    end

endmodule

/* run.sh */
#!/usr/bin/env bash
# Build and run the gfx testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f sim.f --top-module gfx_tb -Mdir obj_dir -o gfx_sim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

output=$(./obj_dir/gfx_sim 2>&1)
status=$?
echo "$output"

if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if echo "$output" | grep -q "^TEST PASSED$"; then
    exit 0
fi

echo "Pass message not found in simulation output"
exit 1

/* sim.f */
common/gfx_pkg.sv
hw/vram.sv
hw/gfx_regs.sv
gfx/line_buffer.sv
gfx/tile_renderer.sv
gfx/gfx_line_fetch.sv
hw/gfx_top.sv
verif/gfx_tb_clk.sv
verif/gfx_top_sva.sv
verif/gfx_tb.sv

/* verif/gfx_tb.sv */
`timescale 1ns/1ps

module gfx_tb;

    localparam int LINE_OFFSET    = 15;
    localparam int NUM_ROWS       = 6;
    localparam int VRAM_WORDS     = 8192;
    localparam int MAP_WORDS      = 2048;
    // Two cycles per APB write plus slack for the readbacks
    localparam int LOAD_CYCLES    = 2 * VRAM_WORDS + 64;
    localparam int TIMEOUT_CYCLES = NUM_ROWS * 1000 + LOAD_CYCLES;

    ////////////////////////////////////////////////////////////////////////////
    // Stimulus table
    ////////////////////////////////////////////////////////////////////////////
    // Zero scroll, plain row, fine x, x wrap past column 63, y scroll, y wrap
    localparam gfx_pkg::scrx_t  TAB_SCRX  [NUM_ROWS] =
        '{9'h000, 9'h000, 9'h005, 9'h1f3, 9'h08a, 9'h1ff};
    localparam gfx_pkg::scry_t  TAB_SCRY  [NUM_ROWS] =
        '{8'h00, 8'h00, 8'h00, 8'h10, 8'h37, 8'hfb};
    localparam gfx_pkg::vline_t TAB_VLINE [NUM_ROWS] =
        '{8'd15, 8'd60, 8'd100, 8'd40, 8'd200, 8'd20};

    logic               clk;
    logic               reset;
    logic               psel;
    logic               penable;
    logic               pwrite;
    logic [7:0]         paddr;
    logic [31:0]        pwdata;
    logic [31:0]        prdata;
    logic               pready;
    gfx_pkg::vline_t    vline;
    logic               line_start;
    gfx_pkg::pix_idx_t  rd_idx;
    gfx_pkg::pixel_t    rd_pixel;

    // Mirror of video RAM contents
    gfx_pkg::vword_t    vmem [0:VRAM_WORDS-1];
    logic [31:0]        lfsr;

    gfx_tb_clk i_clk (
        .clk   (clk),
        .reset (reset)
    );

    gfx_top #(
        .LINE_OFFSET (LINE_OFFSET)
    ) i_dut (
        .clk        (clk),
        .reset      (reset),
        .psel       (psel),
        .penable    (penable),
        .pwrite     (pwrite),
        .paddr      (paddr),
        .pwdata     (pwdata),
        .prdata     (prdata),
        .pready     (pready),
        .vline      (vline),
        .line_start (line_start),
        .rd_idx     (rd_idx),
        .rd_pixel   (rd_pixel)
    );

    ////////////////////////////////////////////////////////////////////////////
    // Helpers
    ////////////////////////////////////////////////////////////////////////////
    // Taps 32, 22, 2, 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic take_bits(input int n, output gfx_pkg::vword_t v);
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr_step(lfsr);
            v = {v[14:0], lfsr[0]};
        end
    endtask

    task automatic step_cycle();
        @(posedge clk);
        #1;
    endtask

    task automatic check_word(input string name, input gfx_pkg::vword_t got,
                              input gfx_pkg::vword_t exp);
        if (got !== exp) begin
            $display("ERR %s: got 0x%h, expected 0x%h", name, got, exp);
            $display("TEST FAILED");
            $fatal(1, "APB readback mismatch");
        end
    endtask

    task automatic check_pixel(input int row, input int x, input gfx_pkg::pixel_t got,
                               input gfx_pkg::pixel_t exp);
        if (got !== exp) begin
            $display("ERR rd_pixel[%0d] row %0d: got 0x%h, expected 0x%h", x, row, got, exp);
            $display("TEST FAILED");
            $fatal(1, "pixel mismatch");
        end
    endtask

    task automatic apb_write(input logic [7:0] addr, input logic [31:0] data);
        psel    = 1'b1;
        penable = 1'b0;
        pwrite  = 1'b1;
        paddr   = addr;
        pwdata  = data;
        step_cycle();
        penable = 1'b1;
        step_cycle();
        psel    = 1'b0;
        penable = 1'b0;
    endtask

    task automatic apb_read(input logic [7:0] addr, output logic [31:0] data);
        psel    = 1'b1;
        penable = 1'b0;
        pwrite  = 1'b0;
        paddr   = addr;
        step_cycle();
        penable = 1'b1;
        @(negedge clk);
        data = prdata;
        // No wait states and no register wider than 16 bits
        check_word("pready", {15'd0, pready}, 16'h0001);
        check_word("prdata[31:16]", data[31:16], 16'h0000);
        step_cycle();
        psel    = 1'b0;
        penable = 1'b0;
    endtask

    // Map entry then pattern word from the tile map layout
    function automatic gfx_pkg::pixel_t expected_pixel(input int x,
            input gfx_pkg::scrx_t sx, input gfx_pkg::scry_t sy, input gfx_pkg::vline_t vl);
        int              tline;
        int              line_in_tile;
        int              pos;
        int              col;
        int              half;
        int              nib_pos;
        gfx_pkg::vword_t entry;
        gfx_pkg::vword_t pattern;
        tline        = (int'(vl) - LINE_OFFSET + int'(sy)) & 255;
        line_in_tile = tline & 7;
        pos          = x + int'(sx[2:0]);
        col          = (int'(sx[8:3]) + pos / 8) % 64;
        entry        = vmem[(tline >> 3) * 64 + col];
        if (entry[10]) begin
            line_in_tile = 7 - line_in_tile;
        end
        half    = (pos % 8) / 4;
        pattern = vmem[int'(entry[8:0]) * 16 + line_in_tile * 2 + half];
        nib_pos = 12 - 4 * (pos % 4);
        return {entry[13:12], pattern[nib_pos +: 4]};
    endfunction

    task automatic pulse_line_start();
        line_start = 1'b1;
        step_cycle();
        line_start = 1'b0;
    endtask

    task automatic wait_render_done();
        logic [31:0] d;
        apb_read(gfx_pkg::REG_STATUS, d);
        while (d[0]) begin
            apb_read(gfx_pkg::REG_STATUS, d);
        end
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Video RAM load
    ////////////////////////////////////////////////////////////////////////////
    task automatic load_vram();
        gfx_pkg::vword_t tile;
        gfx_pkg::vword_t pal;
        gfx_pkg::vword_t flip;
        gfx_pkg::vword_t w;
        logic [31:0]     d;
        apb_write(gfx_pkg::REG_VADDR, 32'd0);
        // Map rows with tiles kept clear of the map area
        for (int a = 0; a < MAP_WORDS; a++) begin
            take_bits(9, tile);
            if (tile < 16'd128) begin
                tile = tile + 16'd128;
            end
            take_bits(2, pal);
            take_bits(1, flip);
            w = {2'b00, pal[1:0], 1'b0, flip[0], 1'b0, tile[8:0]};
            vmem[a] = w;
            apb_write(gfx_pkg::REG_VDATA, {16'd0, w});
        end
        apb_read(gfx_pkg::REG_VADDR, d);
        check_word("vaddr", d[15:0], 16'(MAP_WORDS));
        // Pattern words of tiles 128 to 511
        for (int a = MAP_WORDS; a < VRAM_WORDS; a++) begin
            take_bits(16, w);
            vmem[a] = w;
            apb_write(gfx_pkg::REG_VDATA, {16'd0, w});
        end
        // 13-bit pointer wraps to zero
        apb_read(gfx_pkg::REG_VADDR, d);
        check_word("vaddr", d[15:0], 16'h0000);
    endtask

    task automatic render_row(input int r);
        logic [31:0]     d;
        gfx_pkg::pixel_t exp;
        vline = TAB_VLINE[r];
        apb_write(gfx_pkg::REG_SCRX, {23'd0, TAB_SCRX[r]});
        apb_write(gfx_pkg::REG_SCRY, {24'd0, TAB_SCRY[r]});
        pulse_line_start();
        apb_read(gfx_pkg::REG_STATUS, d);
        check_word("status", d[15:0], 16'h0001);
        wait_render_done();
        repeat (8) step_cycle();
        // Swap halves and start drawing the next video line
        vline = TAB_VLINE[r] + 8'd1;
        pulse_line_start();
        // Read from the far end so the reads cross the new writes
        for (int x = gfx_pkg::LINE_WIDTH - 1; x >= 0; x--) begin
            rd_idx = gfx_pkg::pix_idx_t'(x);
            step_cycle();
            exp = expected_pixel(x, TAB_SCRX[r], TAB_SCRY[r], TAB_VLINE[r]);
            check_pixel(r, x, rd_pixel, exp);
        end
        wait_render_done();
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Main sequence
    ////////////////////////////////////////////////////////////////////////////
    initial begin
        logic [31:0] d;
        psel       = 1'b0;
        penable    = 1'b0;
        pwrite     = 1'b0;
        paddr      = '0;
        pwdata     = '0;
        vline      = '0;
        line_start = 1'b0;
        rd_idx     = '0;
        lfsr       = 32'hb729;
        @(negedge reset);
        step_cycle();

        apb_read(gfx_pkg::REG_STATUS, d);
        check_word("status", d[15:0], 16'h0000);

        // Register readback
        apb_write(gfx_pkg::REG_SCRX, 32'h0000_01a5);
        apb_read(gfx_pkg::REG_SCRX, d);
        check_word("scrx", d[15:0], 16'h01a5);
        apb_write(gfx_pkg::REG_SCRY, 32'h0000_00c3);
        apb_read(gfx_pkg::REG_SCRY, d);
        check_word("scry", d[15:0], 16'h00c3);
        apb_write(gfx_pkg::REG_VADDR, 32'h0000_0abc);
        apb_read(gfx_pkg::REG_VADDR, d);
        check_word("vaddr", d[15:0], 16'h0abc);

        load_vram();
        for (int r = 0; r < NUM_ROWS; r++) begin
            render_row(r);
        end

        $display("TEST PASSED");
        $finish;
    end

    // Watchdog
    initial begin
        repeat (TIMEOUT_CYCLES) @(posedge clk);
        $display("Watchdog expired before all rows were rendered and checked");
        $display("TEST FAILED");
        $fatal(1, "timeout");
    end

endmodule

/* verif/gfx_tb_clk.sv */
`timescale 1ns/1ps

module gfx_tb_clk (
    output logic clk,
    output logic reset
);

    // 10 ns period
    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // Reset held for 4 cycles, released just after an edge
    initial begin
        reset = 1'b1;
        repeat (4) @(posedge clk);
        #1;
        reset = 1'b0;
    end

endmodule

/* verif/gfx_top_sva.sv */
`timescale 1ns/1ps

module gfx_top_sva (
    input logic               clk,
    input logic               reset,
    input logic               busy,
    input logic               vram_we,

    // Fetch to renderer handshake
    input logic               render_start,
    input logic               render_busy,
    input logic               last_pixel,

    // Renderer write port
    input logic               wren,
    input gfx_pkg::pix_idx_t  wridx
);

    // A new word only when the renderer can take it
    a_start_ready: assert property (@(posedge clk) disable iff (reset)
        render_start |-> (!render_busy || last_pixel))
        else $error("render_start while the renderer is busy");

    a_wridx_range: assert property (@(posedge clk) disable iff (reset)
        wren |-> (wridx < gfx_pkg::pix_idx_t'(gfx_pkg::LINE_WIDTH)))
        else $error("line buffer write past the visible width");

    // Single strobe per VDATA access
    a_we_pulse: assert property (@(posedge clk) disable iff (reset)
        vram_we |=> !vram_we)
        else $error("vram_we held for more than one cycle");

    a_busy_reset: assert property (@(posedge clk)
        reset |=> !busy)
        else $error("busy high after reset");

endmodule

bind gfx_top gfx_top_sva i_sva (
    .clk          (clk),
    .reset        (reset),
    .busy         (busy),
    .vram_we      (vram_we),
    .render_start (i_gfx.render_start),
    .render_busy  (i_gfx.render_busy),
    .last_pixel   (i_gfx.render_last_pixel),
    .wren         (i_gfx.wren),
    .wridx        (i_gfx.wridx)
);
